// ==== bench/fmv_tb.sv ====
`timescale 1ns/1ns

module fmv_tb;

    localparam fmv_reg_pkg::reg_data_t IVEC_VALUE = 16'h05A8;
    localparam logic [7:0] TC_B1 = 8'h1D;  // Low three bits go to timecode 27:25
    localparam logic [7:0] TC_B2 = 8'hA6;
    localparam logic [7:0] TC_B3 = 8'h80;
    localparam int TIMER_WAIT = (2 + 1) * 8 * 4 + 16;

    logic                   clk;
    logic                   reset;
    logic [23:1]            address;
    fmv_reg_pkg::reg_data_t din;
    fmv_reg_pkg::reg_data_t dout;
    logic                   uds;
    logic                   lds;
    logic                   write_strobe;
    logic                   cs;
    logic                   bus_ack;
    logic                   intreq;
    logic                   intack;
    logic                   req;
    logic                   ack;
    logic                   rdy;
    logic                   dtc;
    logic                   done_in;
    logic                   vsync;

    logic [15:0] lfsr_state;
    logic [7:0]  stream_q[$];
    logic [50:0] expect_q[$];  // {seq, gop, pic, tmpref, timecode} per picture

    // Reference model of the header rules
    logic        model_seq;
    logic        model_gop;
    logic [9:0]  model_next;
    logic [15:0] model_tmpref;
    logic [31:0] model_tc;

    fmv_decoder_top #(.CLK_PER_TICK(4)) i_dut (
        .clk, .reset, .address, .din, .dout, .uds, .lds, .write_strobe, .cs,
        .bus_ack, .intreq, .intack, .req, .ack, .rdy, .dtc, .done_in, .vsync
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp)
            else stop_with_failure($sformatf("error %s: got %h, expected %h", name, got, exp));
    endtask

    // bus_ack only answers a bus access
    assert property (@(posedge clk) disable iff (reset) bus_ack |-> $past(cs && (uds || lds)))
        else stop_with_failure("bus_ack was raised without a bus access");

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [7:0] filler_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_state[0]};  // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
        return (b == 8'h00) ? 8'hFF : b;  // Never part of a start code
    endfunction

    task automatic bus_cycle(input fmv_reg_pkg::reg_addr_t a, input logic wr,
                             input fmv_reg_pkg::reg_data_t wdata,
                             output fmv_reg_pkg::reg_data_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        address      <= {8'h00, a};
        din          <= wdata;
        write_strobe <= wr;
        cs           <= 1'b1;
        uds          <= 1'b1;
        lds          <= 1'b1;
        @(negedge clk);
        while (!bus_ack) begin
            waited++;
            if (waited > 8) stop_with_failure("timeout waiting for bus_ack in a bus cycle");
            @(negedge clk);
        end
        rdata = dout;
        @(posedge clk);  // Access is taken on this edge
        cs           <= 1'b0;
        uds          <= 1'b0;
        lds          <= 1'b0;
        write_strobe <= 1'b0;
    endtask

    task automatic bus_write(input fmv_reg_pkg::reg_addr_t a, input fmv_reg_pkg::reg_data_t d);
        fmv_reg_pkg::reg_data_t unused;
        bus_cycle(a, 1'b1, d, unused);
    endtask

    task automatic bus_read(input fmv_reg_pkg::reg_addr_t a, output fmv_reg_pkg::reg_data_t d);
        bus_cycle(a, 1'b0, '0, d);
    endtask

    task automatic add_filler(input int n);
        repeat (n) stream_q.push_back(filler_byte());
    endtask

    task automatic add_start_code(input logic [7:0] suffix);
        stream_q.push_back(8'h00);
        stream_q.push_back(8'h00);
        stream_q.push_back(8'h01);
        stream_q.push_back(suffix);
    endtask

    task automatic add_seq_header();
        add_start_code(mpeg_stream_pkg::SC_SEQ);
        stream_q.push_back(8'h16);
        model_seq = 1'b1;
    endtask

    task automatic add_gop_header(input logic [7:0] b1, input logic [7:0] b2,
                                  input logic [7:0] b3);
        add_start_code(mpeg_stream_pkg::SC_GOP);
        stream_q.push_back(8'h08);
        stream_q.push_back(b1);
        stream_q.push_back(b2);
        stream_q.push_back(b3);
        model_gop  = 1'b1;
        model_next = '0;
        model_tc   = {4'b0, b1[2:0], b2, b3[7], 16'h0000};
    endtask

    task automatic add_picture(input logic [9:0] num);
        add_start_code(mpeg_stream_pkg::SC_PIC);
        stream_q.push_back(num[9:2]);
        stream_q.push_back({num[1:0], 6'h08});
        stream_q.push_back(8'hFF);
        stream_q.push_back(8'hF8);
        if (num == model_next) begin  // Out of order keeps the old value
            model_tmpref = {4'b0, num, 2'b0};
            model_next   = model_next + 1'b1;
        end
        expect_q.push_back({model_seq, model_gop, 1'b1, model_tmpref, model_tc});
        model_seq = 1'b0;
        model_gop = 1'b0;
    endtask

    task automatic send_dma_stream();
        logic [7:0] hi;
        logic [7:0] lo;
        if (stream_q.size() % 2 != 0) stream_q.push_back(filler_byte());
        while (stream_q.size() > 0) begin
            hi = stream_q.pop_front();
            lo = stream_q.pop_front();
            @(posedge clk);
            din <= {hi, lo};
            ack <= 1'b1;
            dtc <= 1'b1;
            @(posedge clk);  // Gap cycle for the low byte
            ack <= 1'b0;
            dtc <= 1'b0;
        end
    endtask

    task automatic send_xfer_stream();
        logic [7:0] hi;
        logic [7:0] lo;
        if (stream_q.size() % 2 != 0) stream_q.push_back(filler_byte());
        while (stream_q.size() > 0) begin
            hi = stream_q.pop_front();
            lo = stream_q.pop_front();
            bus_write(fmv_reg_pkg::ADDR_XFER, {hi, lo});
        end
    endtask

    task automatic end_dma();
        @(posedge clk);
        done_in <= 1'b1;
        ack     <= 1'b1;
        @(posedge clk);
        done_in <= 1'b0;
        ack     <= 1'b0;
    endtask

    task automatic pulse_vsync();
        repeat (6) @(posedge clk);
        vsync <= 1'b1;
        repeat (4) @(posedge clk);
        vsync <= 1'b0;
    endtask

    task automatic wait_release(output fmv_reg_pkg::isr_flags_t flags, output int edges);
        logic found;
        found = 1'b0;
        edges = 0;
        while (!found) begin
            if (edges >= 4) stop_with_failure("timeout waiting for vsync to release a picture");
            pulse_vsync();
            edges++;
            bus_read(fmv_reg_pkg::ADDR_ISR, flags);
            found = flags[fmv_reg_pkg::ISR_PIC_BIT];
        end
    endtask

    task automatic check_release();
        fmv_reg_pkg::isr_flags_t flags;
        fmv_reg_pkg::reg_data_t  rd;
        logic [50:0]             exp;
        int                      edges;
        wait_release(flags, edges);
        exp = expect_q.pop_front();
        assert (edges <= 2)
            else stop_with_failure("a queued picture needed more than two vsync edges");
        check_value("isr", {flags[fmv_reg_pkg::ISR_SEQ_BIT], flags[fmv_reg_pkg::ISR_GOP_BIT],
                            flags[fmv_reg_pkg::ISR_PIC_BIT]}, exp[50:48]);
        bus_read(fmv_reg_pkg::ADDR_TIMECD_HI, rd);
        check_value("timecd_hi", rd, exp[31:16]);
        bus_read(fmv_reg_pkg::ADDR_TIMECD_LO, rd);
        check_value("timecd_lo", rd, exp[15:0]);
        bus_read(fmv_reg_pkg::ADDR_TMPREF, rd);
        check_value("tmpref", rd, exp[47:32]);
    endtask

    initial begin
        fmv_reg_pkg::reg_data_t rd;
        int                     waited;
        clk          = 1'b0;
        reset        = 1'b1;
        address      = '0;
        din          = '0;
        uds          = 1'b0;
        lds          = 1'b0;
        write_strobe = 1'b0;
        cs           = 1'b0;
        intack       = 1'b0;
        ack          = 1'b0;
        dtc          = 1'b0;
        done_in      = 1'b0;
        vsync        = 1'b0;
        lfsr_state   = 16'd4214;
        model_seq    = 1'b0;
        model_gop    = 1'b0;
        model_next   = '0;
        model_tmpref = '0;
        model_tc     = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Reset values and register read back
        @(negedge clk);
        check_value("req", req, 0);
        check_value("rdy", rdy, 0);
        check_value("bus_ack", bus_ack, 0);
        check_value("intreq", intreq, 0);
        bus_read(fmv_reg_pkg::ADDR_TCNT, rd);
        check_value("tcnt", rd, 16'h0055);
        bus_write(fmv_reg_pkg::ADDR_IER, 16'h0907);
        bus_read(fmv_reg_pkg::ADDR_IER, rd);
        check_value("ier", rd, 16'h0907);
        bus_write(fmv_reg_pkg::ADDR_IVEC, IVEC_VALUE);
        bus_read(fmv_reg_pkg::ADDR_IVEC, rd);
        check_value("ivec", rd, IVEC_VALUE);
        bus_write(fmv_reg_pkg::ADDR_TCNT, 16'h1234);
        bus_read(fmv_reg_pkg::ADDR_TCNT, rd);
        check_value("tcnt", rd, 16'h1234);
        bus_write(fmv_reg_pkg::ADDR_IER, 16'h0000);

        // DMA start and done handshake
        bus_write(fmv_reg_pkg::ADDR_SYSCMD, fmv_reg_pkg::SYSCMD_DMA_START);
        repeat (5) begin
            @(negedge clk);
            check_value("req", req, 1);
            check_value("rdy", rdy, 1);
        end
        end_dma();
        @(negedge clk);
        check_value("req", req, 0);
        check_value("rdy", rdy, 0);

        // Timer interrupt and vector
        bus_write(fmv_reg_pkg::ADDR_TCNT, 16'h0002);
        bus_write(fmv_reg_pkg::ADDR_TRLD, 16'h0000);
        bus_read(fmv_reg_pkg::ADDR_ISR, rd);
        bus_write(fmv_reg_pkg::ADDR_IER, 16'h0001 << fmv_reg_pkg::ISR_TIM_BIT);
        waited = 0;
        @(negedge clk);
        while (!intreq) begin
            waited++;
            if (waited > TIMER_WAIT) stop_with_failure("timeout waiting for the timer interrupt");
            @(negedge clk);
        end
        @(posedge clk);
        intack <= 1'b1;
        @(negedge clk);
        check_value("dout", dout, {IVEC_VALUE[10:3], IVEC_VALUE[10:3]});
        @(posedge clk);
        intack <= 1'b0;
        bus_read(fmv_reg_pkg::ADDR_ISR, rd);
        check_value("isr_tim", rd[fmv_reg_pkg::ISR_TIM_BIT], 1);
        @(negedge clk);
        check_value("intreq", intreq, 0);  // Read cleared the ISR
        bus_write(fmv_reg_pkg::ADDR_IER, 16'h0000);

        // First stream by DMA
        bus_write(fmv_reg_pkg::ADDR_SYSCMD, fmv_reg_pkg::SYSCMD_DMA_START);
        add_filler(7);
        add_seq_header();
        add_filler(3);
        add_gop_header(TC_B1, TC_B2, TC_B3);
        add_filler(2);
        add_picture(10'd0);
        add_filler(3);
        send_dma_stream();
        end_dma();
        check_release();

        // In order and out of order pictures by XFER writes
        add_filler(4);
        add_picture(10'd1);
        add_filler(2);
        add_picture(10'd5);
        add_filler(1);
        send_xfer_stream();
        check_release();
        check_release();

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
logic/fmv_reg_pkg.sv
logic/mpeg_stream_pkg.sv
logic/fmv_byte_splitter.sv
logic/video_header_parser.sv
logic/picture_event_fifo.sv
logic/fmv_registers.sv
logic/fmv_decoder_top.sv
bench/fmv_tb.sv

// ==== logic/fmv_byte_splitter.sv ====
`timescale 1ns/1ns

module fmv_byte_splitter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        word_valid,
    input  fmv_reg_pkg::reg_data_t      word,
    output logic                        byte_valid,
    output mpeg_stream_pkg::stream_byte_t stream_byte
);

    logic                          pending;  // Low byte still to go out
    mpeg_stream_pkg::stream_byte_t low_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            pending <= word_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) low_q <= word[7:0];
    end

    // High byte goes out at once, held low byte the cycle after
    assign byte_valid  = word_valid || pending;
    assign stream_byte = pending ? low_q : word[15:8];

    // No back-pressure, so words need a gap of one cycle
    assert property (@(posedge clk) disable iff (reset) pending |-> !word_valid)
        else $error("Data word arrived while a low byte was pending");

endmodule

// ==== logic/fmv_decoder_top.sv ====
`timescale 1ns/1ns

module fmv_decoder_top #(
    parameter int CLK_PER_TICK    = 667,
    parameter int FIFO_DEPTH_LOG2 = 6
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [23:1]            address,
    input  fmv_reg_pkg::reg_data_t din,
    output fmv_reg_pkg::reg_data_t dout,
    input  logic                   uds,
    input  logic                   lds,
    input  logic                   write_strobe,
    input  logic                   cs,
    output logic                   bus_ack,
    output logic                   intreq,
    input  logic                   intack,
    output logic                   req,
    input  logic                   ack,
    output logic                   rdy,
    input  logic                   dtc,
    input  logic                   done_in,
    input  logic                   vsync
);

    logic                            word_valid;
    logic                            byte_valid;
    mpeg_stream_pkg::stream_byte_t   stream_byte;
    logic                            event_push;
    mpeg_stream_pkg::picture_event_t event_new;
    logic                            event_valid;
    logic                            event_pop;
    mpeg_stream_pkg::picture_event_t event_head;

    // Only address bits 15:1 are decoded
    fmv_registers #(.CLK_PER_TICK(CLK_PER_TICK)) i_registers (
        .clk, .reset, .addr(address[15:1]), .din, .dout, .uds, .lds, .write_strobe, .cs,
        .bus_ack, .intack, .intreq, .req, .rdy, .ack, .dtc, .done_in, .vsync,
        .word_valid, .event_valid, .event_head, .event_pop
    );

    fmv_byte_splitter i_splitter (
        .clk, .reset, .word_valid, .word(din), .byte_valid, .stream_byte
    );

    video_header_parser i_parser (
        .clk, .reset, .byte_valid, .stream_byte, .event_push, .event_out(event_new)
    );

    picture_event_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) i_fifo (
        .clk, .reset, .event_push, .event_in(event_new), .event_pop, .event_valid, .event_head
    );

endmodule

// ==== logic/fmv_reg_pkg.sv ====
package fmv_reg_pkg;

    typedef logic [14:0] reg_addr_t;  // Address bits 15:1
    typedef logic [15:0] reg_data_t;
    typedef logic [15:0] isr_flags_t;

    // Flag positions shared by ISR and IER
    localparam int ISR_SEQ_BIT   = 0;
    localparam int ISR_GOP_BIT   = 1;
    localparam int ISR_PIC_BIT   = 2;
    localparam int ISR_TIM_BIT   = 8;
    localparam int ISR_VSYNC_BIT = 11;

    // Word addresses
    localparam reg_addr_t ADDR_TIMECD_HI = 15'h202C;
    localparam reg_addr_t ADDR_TIMECD_LO = 15'h202D;
    localparam reg_addr_t ADDR_TMPREF    = 15'h202E;
    localparam reg_addr_t ADDR_IER       = 15'h2030;
    localparam reg_addr_t ADDR_ISR       = 15'h2031;
    localparam reg_addr_t ADDR_TCNT      = 15'h2032;  // Timer compare
    localparam reg_addr_t ADDR_TRLD      = 15'h2057;  // Timer reload, write only
    localparam reg_addr_t ADDR_SYSCMD    = 15'h2060;
    localparam reg_addr_t ADDR_IVEC      = 15'h206E;
    localparam reg_addr_t ADDR_XFER      = 15'h206F;  // Stream data by CPU writes

    localparam reg_data_t SYSCMD_DMA_START = 16'h8000;

endpackage

// ==== logic/fmv_registers.sv ====
`timescale 1ns/1ns

module fmv_registers #(
    parameter int CLK_PER_TICK = 667
) (
    input  logic                            clk,
    input  logic                            reset,
    input  fmv_reg_pkg::reg_addr_t          addr,
    input  fmv_reg_pkg::reg_data_t          din,
    output fmv_reg_pkg::reg_data_t          dout,
    input  logic                            uds,
    input  logic                            lds,
    input  logic                            write_strobe,
    input  logic                            cs,
    output logic                            bus_ack,
    input  logic                            intack,
    output logic                            intreq,
    output logic                            req,
    output logic                            rdy,
    input  logic                            ack,
    input  logic                            dtc,
    input  logic                            done_in,
    input  logic                            vsync,
    output logic                            word_valid,
    input  logic                            event_valid,
    input  mpeg_stream_pkg::picture_event_t event_head,
    output logic                            event_pop
);

    localparam int PRESC_W = $clog2(CLK_PER_TICK + 1);
    localparam int TPB     = mpeg_stream_pkg::TIMER_PRESCALE_BITS;

    fmv_reg_pkg::isr_flags_t     isr;
    fmv_reg_pkg::isr_flags_t     ier;
    fmv_reg_pkg::reg_data_t      ivec;
    fmv_reg_pkg::reg_data_t      tcnt;
    mpeg_stream_pkg::timecode_t  timecode;
    mpeg_stream_pkg::tmpref_t    tmpref;

    logic               dma_active;
    logic               vsync_q;
    logic               vsync_phase;  // Every second vsync edge releases
    logic [PRESC_W-1:0] presc_cnt;
    logic [15+TPB:0]    timer_cnt;

    logic access;
    logic wr_take;
    logic rd_take;
    logic vsync_rise;
    logic tick;

    assign access  = cs && (uds || lds);
    assign wr_take = access && bus_ack && write_strobe;
    assign rd_take = access && bus_ack && !write_strobe;

    assign word_valid = (ack && dtc) || (wr_take && addr == fmv_reg_pkg::ADDR_XFER);
    assign req        = dma_active;
    assign rdy        = dma_active;
    assign intreq     = (isr & ier) != '0;

    assign vsync_rise = vsync && !vsync_q;
    assign event_pop  = vsync_rise && vsync_phase && event_valid;
    assign tick       = presc_cnt == PRESC_W'(CLK_PER_TICK - 1);

    always_comb begin
        dout = '0;
        case (addr)
            fmv_reg_pkg::ADDR_TIMECD_HI: dout = timecode[31:16];
            fmv_reg_pkg::ADDR_TIMECD_LO: dout = timecode[15:0];
            fmv_reg_pkg::ADDR_TMPREF:    dout = tmpref;
            fmv_reg_pkg::ADDR_IER:       dout = ier;
            fmv_reg_pkg::ADDR_ISR:       dout = isr;
            fmv_reg_pkg::ADDR_TCNT:      dout = tcnt;
            fmv_reg_pkg::ADDR_IVEC:      dout = ivec;
            default: ;
        endcase
        // Vector cycle during interrupt acknowledge
        if (intack) dout = {ivec[10:3], ivec[10:3]};
    end

    always_ff @(posedge clk) begin
        if (event_pop) begin
            timecode <= event_head[mpeg_stream_pkg::EV_TIMECODE_LSB +: 32];
            tmpref   <= event_head[mpeg_stream_pkg::EV_TMPREF_LSB +: 16];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack     <= 1'b0;
            isr         <= '0;
            ier         <= '0;
            ivec        <= '0;
            tcnt        <= 16'h0055;
            dma_active  <= 1'b0;
            vsync_q     <= 1'b0;
            vsync_phase <= 1'b0;
            presc_cnt   <= '0;
            timer_cnt   <= '0;
        end else begin
            vsync_q <= vsync;
            if (vsync_rise) begin
                isr[fmv_reg_pkg::ISR_VSYNC_BIT] <= 1'b1;
                vsync_phase <= !vsync_phase;
            end
            if (event_pop) begin
                isr[fmv_reg_pkg::ISR_SEQ_BIT] <= event_head[mpeg_stream_pkg::EV_SEQ_BIT];
                isr[fmv_reg_pkg::ISR_GOP_BIT] <= event_head[mpeg_stream_pkg::EV_GOP_BIT];
                isr[fmv_reg_pkg::ISR_PIC_BIT] <= event_head[mpeg_stream_pkg::EV_PIC_BIT];
            end

            presc_cnt <= tick ? '0 : presc_cnt + 1'b1;
            if (tick) begin
                if (timer_cnt[TPB +: 16] == tcnt) begin
                    isr[fmv_reg_pkg::ISR_TIM_BIT] <= 1'b1;
                    timer_cnt <= '0;
                end else begin
                    timer_cnt <= timer_cnt + 1'b1;
                end
            end

            if (done_in && ack) dma_active <= 1'b0;

            bus_ack <= access ? !bus_ack : 1'b0;  // Two cycle bus handshake

            if (rd_take && addr == fmv_reg_pkg::ADDR_ISR) isr <= '0;  // Clear on read

            if (wr_take) begin
                case (addr)
                    fmv_reg_pkg::ADDR_IER:  ier <= din;
                    fmv_reg_pkg::ADDR_TCNT: tcnt <= din;
                    fmv_reg_pkg::ADDR_TRLD: timer_cnt <= '0;
                    fmv_reg_pkg::ADDR_IVEC: ivec <= din;
                    fmv_reg_pkg::ADDR_SYSCMD: begin
                        if (din == fmv_reg_pkg::SYSCMD_DMA_START) dma_active <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== logic/mpeg_stream_pkg.sv ====
package mpeg_stream_pkg;

    typedef logic [7:0] stream_byte_t;

    // Start code suffixes after 00 00 01
    localparam stream_byte_t SC_SEQ = 8'hB3;
    localparam stream_byte_t SC_GOP = 8'hB8;
    localparam stream_byte_t SC_PIC = 8'h00;

    typedef enum logic [3:0] {
        IDLE, MAGIC0, MAGIC2, MAGIC_MATCH,
        GOP0, GOP1, GOP2, GOP3,
        PIC0, PIC1, PIC2, PIC3,
        SLICE0, SEQHDR
    } parser_state_t;

    typedef logic [31:0] timecode_t;
    typedef logic [15:0] tmpref_t;

    // Event layout is {seq, gop, pic, tmpref, timecode}
    typedef logic [50:0] picture_event_t;
    localparam int EV_SEQ_BIT      = 50;
    localparam int EV_GOP_BIT      = 49;
    localparam int EV_PIC_BIT      = 48;
    localparam int EV_TMPREF_LSB   = 32;
    localparam int EV_TIMECODE_LSB = 0;

    localparam int TIMER_PRESCALE_BITS = 3;  // Timer count is compared divided by 8

endpackage

// ==== logic/picture_event_fifo.sv ====
`timescale 1ns/1ns

module picture_event_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 6
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            event_push,
    input  mpeg_stream_pkg::picture_event_t event_in,
    input  logic                            event_pop,
    output logic                            event_valid,
    output mpeg_stream_pkg::picture_event_t event_head
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    mpeg_stream_pkg::picture_event_t mem [DEPTH];

    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr_next;
    logic [FIFO_DEPTH_LOG2:0]   count;
    logic                       hide_q;  // Head register still holds stale data

    assign rd_ptr_next = event_pop ? rd_ptr + 1'b1 : rd_ptr;
    assign event_valid = (count != '0) && !hide_q;

    always_ff @(posedge clk) begin
        if (event_push) mem[wr_ptr] <= event_in;
        event_head <= mem[rd_ptr_next];  // Registered read
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            hide_q <= 1'b0;
        end else begin
            if (event_push) wr_ptr <= wr_ptr + 1'b1;
            rd_ptr <= rd_ptr_next;
            if (event_push && !event_pop) count <= count + 1'b1;
            if (event_pop && !event_push) count <= count - 1'b1;
            // Read and write on the same slot return the old word
            hide_q <= event_push && (wr_ptr == rd_ptr_next);
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        event_push |-> count != (FIFO_DEPTH_LOG2 + 1)'(DEPTH))
        else $error("Picture event pushed into a full FIFO");

    assert property (@(posedge clk) disable iff (reset) event_pop |-> count != '0)
        else $error("Picture event popped from an empty FIFO");

endmodule

// ==== logic/video_header_parser.sv ====
`timescale 1ns/1ns

module video_header_parser (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            byte_valid,
    input  mpeg_stream_pkg::stream_byte_t   stream_byte,
    output logic                            event_push,
    output mpeg_stream_pkg::picture_event_t event_out
);

    mpeg_stream_pkg::parser_state_t state;

    logic       seq_flag;
    logic       gop_flag;
    logic       pic_flag;
    logic [9:0] seq_num;       // Temporal sequence number of current picture
    logic [9:0] expected_num;  // Next number in order since the last GOP
    logic [9:0] tmp_q;         // Lands in tmpref bits 11:2
    logic [11:0] tc_q;         // Timecode bits 27:16

    assign event_out = {seq_flag, gop_flag, pic_flag,
                        4'b0, tmp_q, 2'b0,
                        4'b0, tc_q, 16'b0};

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= mpeg_stream_pkg::IDLE;
            event_push   <= 1'b0;
            seq_flag     <= 1'b0;
            gop_flag     <= 1'b0;
            pic_flag     <= 1'b0;
            expected_num <= '0;
        end else begin
            event_push <= 1'b0;
            if (event_push) begin  // Flags belong to the event just pushed
                seq_flag <= 1'b0;
                gop_flag <= 1'b0;
                pic_flag <= 1'b0;
            end

            if (byte_valid) begin
                state <= mpeg_stream_pkg::IDLE;  // Anything unexpected drops back
                case (state)
                    mpeg_stream_pkg::IDLE: begin
                        if (stream_byte == 8'h00) state <= mpeg_stream_pkg::MAGIC0;
                    end
                    mpeg_stream_pkg::MAGIC0: begin
                        if (stream_byte == 8'h00) state <= mpeg_stream_pkg::MAGIC2;
                    end
                    mpeg_stream_pkg::MAGIC2: begin
                        // Extra zero bytes before the 01 are allowed
                        if (stream_byte == 8'h00) state <= mpeg_stream_pkg::MAGIC2;
                        if (stream_byte == 8'h01) state <= mpeg_stream_pkg::MAGIC_MATCH;
                    end
                    mpeg_stream_pkg::MAGIC_MATCH: begin
                        case (stream_byte)
                            mpeg_stream_pkg::SC_SEQ: state <= mpeg_stream_pkg::SEQHDR;
                            mpeg_stream_pkg::SC_GOP: state <= mpeg_stream_pkg::GOP0;
                            mpeg_stream_pkg::SC_PIC: state <= mpeg_stream_pkg::PIC0;
                            8'h01:                   state <= mpeg_stream_pkg::SLICE0;
                            default: ;
                        endcase
                    end
                    mpeg_stream_pkg::SEQHDR: seq_flag <= 1'b1;
                    mpeg_stream_pkg::GOP0:   state <= mpeg_stream_pkg::GOP1;
                    mpeg_stream_pkg::GOP1: begin
                        tc_q[11:9] <= stream_byte[2:0];  // Timecode 27:25
                        state      <= mpeg_stream_pkg::GOP2;
                    end
                    mpeg_stream_pkg::GOP2: begin
                        tc_q[8:1] <= stream_byte;        // Timecode 24:17
                        state     <= mpeg_stream_pkg::GOP3;
                    end
                    mpeg_stream_pkg::GOP3: begin
                        tc_q[0]      <= stream_byte[7];
                        gop_flag     <= 1'b1;
                        expected_num <= '0;
                    end
                    mpeg_stream_pkg::PIC0: begin
                        seq_num[9:2] <= stream_byte;
                        state        <= mpeg_stream_pkg::PIC1;
                    end
                    mpeg_stream_pkg::PIC1: begin
                        seq_num[1:0] <= stream_byte[7:6];
                        state        <= mpeg_stream_pkg::PIC2;
                    end
                    mpeg_stream_pkg::PIC2: begin
                        // Out of order pictures keep the old tmpref
                        if (seq_num == expected_num) begin
                            tmp_q        <= seq_num;
                            expected_num <= expected_num + 1'b1;
                        end
                        state <= mpeg_stream_pkg::PIC3;
                    end
                    mpeg_stream_pkg::PIC3: begin
                        pic_flag   <= 1'b1;
                        event_push <= 1'b1;
                    end
                    default: ;  // SLICE0 just ends the header
                endcase
            end
        end
    end

endmodule
